// ==== bench/exec_stimulus.txt ====
# instr(hex) expect_wb expected_rd expected_data(hex) expect_illegal
# rd and the two flags are decimal; data is ignored when expect_wb is 0
002082B3 1 5 00000000 0
06400093 1 1 00000064 0
FF900113 1 2 FFFFFFF9 0
FFF12193 1 3 00000001 0
00513213 1 4 00000000 0
0F00C313 1 6 00000094 0
7030E393 1 7 00000767 0
0FF17413 1 8 000000F9 0
00409493 1 9 00000640 0
01C15513 1 10 0000000F 0
40215593 1 11 FFFFFFFE 0
ABCDE637 1 12 ABCDE000 0
002086B3 1 13 0000005D 0
40168733 1 14 FFFFFFF9 0
003717B3 1 15 FFFFFFF2 0
0017A833 1 16 00000001 0
0017B8B3 1 17 00000000 0
00764933 1 18 ABCDE767 0
003959B3 1 19 55E6F3B3 0
40A95A33 1 20 FFFF579B 0
001A6AB3 1 21 FFFF57FF 0
008AFB33 1 22 000000F9 0
00508013 1 0 00000069 0
00000BB3 1 23 00000000 0
00012083 0 0 00000000 1
02108133 0 0 00000000 1
40009093 0 0 00000000 1
00208C33 1 24 0000005D 0

// ==== project.f ====
design/riscv_pkg.sv
design/alu.sv
design/reg_file.sv
design/instr_decoder.sv
design/issue_stage.sv
design/exec_core.sv
bench/clock_gen.sv
bench/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - design/riscv_pkg.sv
  - design/alu.sv
  - design/reg_file.sv
  - design/instr_decoder.sv
  - design/issue_stage.sv
  - design/exec_core.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/exec_core_tb.sv

// ==== bench/exec_core_tb.sv ====
`timescale 1ns/1ps

module exec_core_tb;

    logic                clk;
    logic                rst_n;
    logic                instr_valid;
    riscv_pkg::instr_t   instr;
    logic                wb_valid;
    riscv_pkg::reg_idx_t wb_rd;
    riscv_pkg::word_t    wb_data;
    logic                illegal;

    logic [31:0] vec_instr [$];
    logic        vec_wb [$];
    logic [4:0]  vec_rd [$];
    logic [31:0] vec_data [$];
    logic        vec_illegal [$];

    int     error_count = 0;
    int     check_count = 0;
    integer seed = 40190;
    logic   loaded = 1'b0;

    clock_gen #(.half_period(10)) clock_gen_inst (.clk(clk));

    exec_core #(.reg_addr_width(5)) exec_core_inst (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .illegal(illegal)
    );

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH t=%0t %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // true when the instruction word names idx in its rs1 or rs2 field.
    function automatic logic reads_register(input logic [31:0] word, input logic [4:0] idx);
        return (word[19:15] == idx) || (word[24:20] == idx);
    endfunction

    task automatic read_stimulus();
        int          fd;
        string       line;
        logic [31:0] f_instr;
        logic [31:0] f_data;
        int          f_wb;
        int          f_rd;
        int          f_ill;
        fd = $fopen("bench/exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/exec_stimulus.txt");
            error_count++;
            return;
        end
        // comment lines do not parse as five fields and are skipped.
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %d %d %h %d", f_instr, f_wb, f_rd, f_data, f_ill) == 5) begin
                vec_instr.push_back(f_instr);
                vec_wb.push_back(f_wb != 0);
                vec_rd.push_back(f_rd[4:0]);
                vec_data.push_back(f_data);
                vec_illegal.push_back(f_ill != 0);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int gap;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        read_stimulus();
        if (vec_instr.size() == 0) begin
            $display("no stimulus vectors were loaded");
            error_count++;
        end
        loaded = 1'b1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < vec_instr.size(); i++) begin
            instr       = vec_instr[i];
            instr_valid = 1'b1;
            // the result shows up in the cycle after the sampling edge.
            @(negedge clk);
            compare_field("illegal", vec_illegal[i], illegal);
            compare_field("wb_valid", vec_wb[i], wb_valid);
            if (vec_wb[i]) begin
                compare_field("wb_rd", vec_rd[i], wb_rd);
                compare_field("wb_data", vec_data[i], wb_data);
            end
            instr_valid = 1'b0;
            gap = $unsigned($random(seed)) % 4;
            // a dependent successor goes back to back so it must take the forwarding path.
            if (i + 1 < vec_instr.size() && vec_wb[i]
                    && reads_register(vec_instr[i + 1], vec_rd[i])) begin
                gap = 0;
            end
            repeat (gap) begin
                @(negedge clk);
                compare_field("wb_valid", 32'd0, wb_valid);
                compare_field("illegal", 32'd0, illegal);
            end
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // each vector takes at most four cycles, so five per vector leaves margin.
    initial begin
        wait (loaded);
        repeat (vec_instr.size() * 5 + 20) @(posedge clk);
        $display("run timed out before all stimulus vectors were applied");
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int half_period = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

// ==== design/exec_core.sv ====
`timescale 1ns/1ps

module exec_core #(
    parameter int reg_addr_width = 5
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  riscv_pkg::instr_t   instr,
    output logic                wb_valid,
    output riscv_pkg::reg_idx_t wb_rd,
    output riscv_pkg::word_t    wb_data,
    output logic                illegal
);

    riscv_pkg::reg_idx_t rs1;
    riscv_pkg::reg_idx_t rs2;
    riscv_pkg::reg_idx_t rd;
    riscv_pkg::word_t    imm;
    logic                use_imm;
    riscv_pkg::alu_op_t  alu_op;
    logic                writes_rd;
    logic                legal;
    riscv_pkg::word_t    rs1_data;
    riscv_pkg::word_t    rs2_data;
    logic                ex_valid;
    riscv_pkg::reg_idx_t ex_rd;
    riscv_pkg::word_t    ex_a;
    riscv_pkg::word_t    ex_b;
    riscv_pkg::alu_op_t  ex_op;
    logic                ex_writes;
    logic                ex_illegal;
    riscv_pkg::word_t    ex_result;
    logic                write_en;

    // writeback happens in the execute cycle, so the write port is driven from the issue stage.
    assign write_en = ex_valid && ex_writes;
    assign wb_valid = write_en;
    assign wb_rd    = ex_rd;
    assign wb_data  = ex_result;
    assign illegal  = ex_valid && ex_illegal;

    instr_decoder #(.reg_addr_width(reg_addr_width)) instr_decoder_inst (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .use_imm(use_imm),
        .alu_op(alu_op), .writes_rd(writes_rd), .legal(legal)
    );

    reg_file #(.reg_addr_width(reg_addr_width)) reg_file_inst (
        .clk(clk), .rst_n(rst_n), .rs1_addr(rs1), .rs2_addr(rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .rd_addr(ex_rd),
        .rd_data(ex_result), .write_en(write_en)
    );

    issue_stage issue_stage_inst (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .rd(rd),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .use_imm(use_imm),
        .writes_rd(writes_rd), .legal(legal), .alu_op(alu_op), .ex_valid(ex_valid),
        .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b), .ex_op(ex_op),
        .ex_writes(ex_writes), .ex_illegal(ex_illegal)
    );

    alu alu_inst (
        .a(ex_a), .b(ex_b), .op(ex_op), .result(ex_result)
    );

endmodule

// ==== design/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  riscv_pkg::reg_idx_t rd,
    input  riscv_pkg::word_t    rs1_data,
    input  riscv_pkg::word_t    rs2_data,
    input  riscv_pkg::word_t    imm,
    input  logic                use_imm,
    input  logic                writes_rd,
    input  logic                legal,
    input  riscv_pkg::alu_op_t  alu_op,
    output logic                ex_valid,
    output riscv_pkg::reg_idx_t ex_rd,
    output riscv_pkg::word_t    ex_a,
    output riscv_pkg::word_t    ex_b,
    output riscv_pkg::alu_op_t  ex_op,
    output logic                ex_writes,
    output logic                ex_illegal
);

    riscv_pkg::word_t b_sel;

    assign b_sel = use_imm ? imm : rs2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            ex_writes  <= 1'b0;
            ex_illegal <= 1'b0;
        end else begin
            ex_valid <= instr_valid;
            if (instr_valid) begin
                ex_writes  <= writes_rd;
                ex_illegal <= !legal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex_rd <= rd;
            ex_a  <= rs1_data;
            ex_b  <= b_sel;
            ex_op <= alu_op;
        end
    end

    // an illegal instruction must never reach the register file write port.
    no_illegal_write: assert property (
        @(posedge clk) disable iff (!rst_n) ex_valid |-> !(ex_writes && ex_illegal)
    ) else $error("illegal instruction marked as writing rd");

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder #(
    parameter int reg_addr_width = 5
) (
    input  riscv_pkg::instr_t   instr,
    output riscv_pkg::reg_idx_t rs1,
    output riscv_pkg::reg_idx_t rs2,
    output riscv_pkg::reg_idx_t rd,
    output riscv_pkg::word_t    imm,
    output logic                use_imm,
    output riscv_pkg::alu_op_t  alu_op,
    output logic                writes_rd,
    output logic                legal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       enc_ok;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       regs_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm = (opcode == riscv_pkg::OPC_LUI) ? {instr[31:12], 12'b0}
                                                : {{20{instr[31]}}, instr[31:20]};

    always_comb begin
        enc_ok   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        use_imm  = 1'b1;
        case (funct3)
            riscv_pkg::F3_ADD_SUB: alu_op = riscv_pkg::ALU_ADD;
            riscv_pkg::F3_SLL:     alu_op = riscv_pkg::ALU_SLL;
            riscv_pkg::F3_SLT:     alu_op = riscv_pkg::ALU_SLT;
            riscv_pkg::F3_SLTU:    alu_op = riscv_pkg::ALU_SLTU;
            riscv_pkg::F3_XOR:     alu_op = riscv_pkg::ALU_XOR;
            riscv_pkg::F3_SRL_SRA: alu_op = funct7[5] ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
            riscv_pkg::F3_OR:      alu_op = riscv_pkg::ALU_OR;
            default:               alu_op = riscv_pkg::ALU_AND;
        endcase

        case (opcode)
            riscv_pkg::OPC_OP: begin
                use_imm  = 1'b0;
                uses_rs2 = 1'b1;
                if (funct3 == riscv_pkg::F3_ADD_SUB && funct7 == riscv_pkg::F7_ALT) begin
                    alu_op = riscv_pkg::ALU_SUB;
                end else if (funct7 != riscv_pkg::F7_BASE) begin
                    enc_ok = (funct3 == riscv_pkg::F3_SRL_SRA && funct7 == riscv_pkg::F7_ALT);
                end
            end
            riscv_pkg::OPC_OP_IMM: begin
                // only the shifts carry a funct7 field in the immediate.
                if (funct3 == riscv_pkg::F3_SLL) begin
                    enc_ok = (funct7 == riscv_pkg::F7_BASE);
                end else if (funct3 == riscv_pkg::F3_SRL_SRA) begin
                    enc_ok = (funct7 == riscv_pkg::F7_BASE || funct7 == riscv_pkg::F7_ALT);
                end
            end
            riscv_pkg::OPC_LUI: begin
                uses_rs1 = 1'b0;
                alu_op   = riscv_pkg::ALU_PASS_B;
            end
            default: begin
                enc_ok = 1'b0;
            end
        endcase
    end

    // the rv32e file has only 16 registers, so a higher index is rejected.
    assign regs_ok = (int'(rd) < 2**reg_addr_width)
                  && (!uses_rs1 || int'(rs1) < 2**reg_addr_width)
                  && (!uses_rs2 || int'(rs2) < 2**reg_addr_width);

    assign legal     = enc_ok && regs_ok;
    assign writes_rd = legal;

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int reg_addr_width = 5
) (
    input  logic                clk,
    input  logic                rst_n,
    input  riscv_pkg::reg_idx_t rs1_addr,
    input  riscv_pkg::reg_idx_t rs2_addr,
    output riscv_pkg::word_t    rs1_data,
    output riscv_pkg::word_t    rs2_data,
    input  riscv_pkg::reg_idx_t rd_addr,
    input  riscv_pkg::word_t    rd_data,
    input  logic                write_en
);

    riscv_pkg::word_t          regs [2**reg_addr_width];
    logic [reg_addr_width-1:0] rs1_sel;
    logic [reg_addr_width-1:0] rs2_sel;
    logic [reg_addr_width-1:0] rd_sel;

    assign rs1_sel = rs1_addr[reg_addr_width-1:0];
    assign rs2_sel = rs2_addr[reg_addr_width-1:0];
    assign rd_sel  = rd_addr[reg_addr_width-1:0];

    // a write in the same cycle is forwarded so a dependent instruction needs no stall.
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (write_en && rd_addr == rs1_addr) begin
            rs1_data = rd_data;
        end else begin
            rs1_data = regs[rs1_sel];
        end

        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (write_en && rd_addr == rs2_addr) begin
            rs2_data = rd_data;
        end else begin
            rs2_data = regs[rs2_sel];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd_addr != '0) begin
            regs[rd_sel] <= rd_data;
        end
    end

    x0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n) write_en |=> regs[0] == '0
    ) else $error("x0 holds a nonzero value after a write");

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  riscv_pkg::word_t   a,
    input  riscv_pkg::word_t   b,
    input  riscv_pkg::alu_op_t op,
    output riscv_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            riscv_pkg::ALU_ADD: begin
                result = a + b;
            end
            riscv_pkg::ALU_SUB: begin
                result = a - b;
            end
            riscv_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            riscv_pkg::ALU_SLT: begin
                result = {31'b0, lt_signed};
            end
            riscv_pkg::ALU_SLTU: begin
                result = {31'b0, lt_unsigned};
            end
            riscv_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            riscv_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            riscv_pkg::ALU_SRA: begin
                result = riscv_pkg::word_t'($signed(a) >>> shamt);
            end
            riscv_pkg::ALU_OR: begin
                result = a | b;
            end
            riscv_pkg::ALU_AND: begin
                result = a & b;
            end
            riscv_pkg::ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== design/riscv_pkg.sv ====
package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // major opcodes handled by the slice.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 selects sub and sra when it holds the alternate value.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage
